/* common/soc_bus_pkg.sv */
// load/store bus package
// bus widths, address map and decoder target select

package soc_bus_pkg;

  ////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////

  localparam int unsigned addr_w = 15;          // byte address
  localparam int unsigned data_w = 32;
  localparam int unsigned ben_w  = data_w/8;    // one enable per byte

  // byte offset inside a word, 2 bits for 32-bit data
  localparam int unsigned byte_ofs_w = $clog2(ben_w);

  ////////////////////////////////////////
  // address map
  ////////////////////////////////////////

  // bit 14 splits the space in half, memory below and peripherals above
  localparam int unsigned sel_bit = 14;
  // inside the peripheral half, bit 6 picks gpio (0) or uart (1)
  localparam int unsigned per_bit = 6;

  // word address into the lower half, 4096 words
  localparam int unsigned mem_aw = sel_bit - byte_ofs_w;

  ////////////////////////////////////////
  // decoder targets
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    sel_mem,   // data memory
    sel_gpio,  // gpio controller
    sel_uart   // uart transmitter
  } target_e;

endpackage : soc_bus_pkg

/* common/soc_periph_pkg.sv */
// peripheral package
// register offsets for gpio and uart, baud divider, uart tx states

package soc_periph_pkg;

  ////////////////////////////////////////
  // gpio
  ////////////////////////////////////////

  localparam int unsigned gpio_w = 32;  // pin count

  // byte offsets, only bits 5:2 take part in the compare
  localparam logic [6:0] reg_out = 7'h00;  // output value
  localparam logic [6:0] reg_oen = 7'h04;  // output enable
  localparam logic [6:0] reg_in  = 7'h08;  // synchronized input, read only

  ////////////////////////////////////////
  // uart
  ////////////////////////////////////////

  localparam logic [6:0] reg_txd  = 7'h40;  // transmit byte, write only
  localparam logic [6:0] reg_stat = 7'h44;  // bit 0 busy

  // clocks per bit, kept short so frames simulate fast
  localparam int unsigned baud_div = 8;
  localparam int unsigned baud_cw  = $clog2(baud_div);

  // data bits per frame and a bit counter with headroom above 7
  localparam int unsigned data_bits = 8;
  localparam int unsigned bit_cw    = $clog2(data_bits + 1);

  // transmitter states
  typedef enum logic [1:0] {
    st_idle,   // line high, waiting for a byte
    st_start,  // start bit, line low
    st_data,   // 8 data bits, lsb first
    st_stop    // stop bit, line high
  } uart_state_e;

endpackage : soc_periph_pkg

/* verilog/soc_bus_dec.sv */
// load/store bus decoder
// splits the request strobe into memory, gpio and uart strobes
// and steers the returning read data back one cycle later

`timescale 1ns/1ns

module soc_bus_dec (
  input  logic                          clk,
  input  logic                          arst_n,
  // bus from outside
  input  logic                          ls_vld,
  input  logic                          ls_wen,
  input  logic [soc_bus_pkg::addr_w-1:0] ls_adr,
  output logic [soc_bus_pkg::data_w-1:0] ls_rdt,
  // target strobes
  output logic                          mem_vld,
  output logic                          gpio_vld,
  output logic                          uart_vld,
  // target read data, registered inside each target
  input  logic [soc_bus_pkg::data_w-1:0] mem_rdt,
  input  logic [soc_bus_pkg::data_w-1:0] gpio_rdt,
  input  logic [soc_bus_pkg::data_w-1:0] uart_rdt
);

  import soc_bus_pkg::*;

  target_e tgt;     // target of the current request
  target_e rd_tgt;  // target of the read issued last cycle

  ////////////////////////////////////////
  // request decode
  ////////////////////////////////////////

  always_comb begin
    if (!ls_adr[sel_bit]) begin
      tgt = sel_mem;                 // lower half
    end else if (!ls_adr[per_bit]) begin
      tgt = sel_gpio;                // 0x00..0x3f
    end else begin
      tgt = sel_uart;                // 0x40..0x7f
    end
  end

  assign mem_vld  = ls_vld & (tgt == sel_mem);
  assign gpio_vld = ls_vld & (tgt == sel_gpio);
  assign uart_vld = ls_vld & (tgt == sel_uart);

  ////////////////////////////////////////
  // read return path
  ////////////////////////////////////////

  // remember who answers next cycle, writes leave it alone
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_tgt <= sel_mem;
    end else if (ls_vld && !ls_wen) begin
      rd_tgt <= tgt;
    end
  end

  // data is only meaningful the cycle after a read
  always_comb begin
    case (rd_tgt)
      sel_gpio: ls_rdt = gpio_rdt;
      sel_uart: ls_rdt = uart_rdt;
      default:  ls_rdt = mem_rdt;
    endcase
  end

  // never more than one target strobed per request
  a_one_target : assert property (
    @(posedge clk) disable iff (!arst_n)
    $onehot0({mem_vld, gpio_vld, uart_vld})
  );

endmodule : soc_bus_dec

/* verilog/soc_data_mem.sv */
// data memory
// word organized RAM with byte enable writes and a registered read

`timescale 1ns/1ns

module soc_data_mem (
  input  logic                          clk,
  input  logic                          vld,
  input  logic                          wen,
  input  logic [soc_bus_pkg::addr_w-1:0] adr,
  input  logic [soc_bus_pkg::ben_w-1:0]  ben,
  input  logic [soc_bus_pkg::data_w-1:0] wdt,
  output logic [soc_bus_pkg::data_w-1:0] rdt
);

  import soc_bus_pkg::*;

  // 4096 words of 32 bits
  logic [data_w-1:0] mem [2**mem_aw];

  logic [mem_aw-1:0] widx;  // word index

  // drop the byte offset, bit 14 was already used by the decoder
  assign widx = adr[byte_ofs_w +: mem_aw];

  ////////////////////////////////////////
  // write port
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (vld && wen) begin
      for (int b = 0; b < ben_w; b++) begin
        if (ben[b]) begin
          mem[widx][8*b +: 8] <= wdt[8*b +: 8];  // enabled bytes only
        end
      end
    end
  end

  ////////////////////////////////////////
  // read port
  ////////////////////////////////////////

  // one cycle latency, rdt holds between reads
  always_ff @(posedge clk) begin
    if (vld && !wen) begin
      rdt <= mem[widx];
    end
  end

  // an unknown address would write or read a random word
  a_adr_known : assert property (
    @(posedge clk) vld |-> !$isunknown(adr)
  );

endmodule : soc_data_mem

/* verilog/soc_gpio.sv */
// gpio controller
// output and output enable registers plus a two flop
// synchronizer on the input pins, all readable by offset

`timescale 1ns/1ns

module soc_gpio (
  input  logic                             clk,
  input  logic                             arst_n,
  // bus side
  input  logic                             vld,
  input  logic                             wen,
  input  logic [soc_bus_pkg::addr_w-1:0]    adr,
  input  logic [soc_bus_pkg::data_w-1:0]    wdt,
  output logic [soc_bus_pkg::data_w-1:0]    rdt,
  // pins
  output logic [soc_periph_pkg::gpio_w-1:0] gpio_out,
  output logic [soc_periph_pkg::gpio_w-1:0] gpio_oe,
  input  logic [soc_periph_pkg::gpio_w-1:0] gpio_in
);

  import soc_bus_pkg::*;
  import soc_periph_pkg::*;

  logic              wr_out;  // write to reg_out
  logic              wr_oen;  // write to reg_oen
  logic [gpio_w-1:0] in_meta; // first sync stage
  logic [gpio_w-1:0] in_sync; // second stage, this one is read

  assign wr_out = vld & wen & (adr[5:2] == reg_out[5:2]);
  assign wr_oen = vld & wen & (adr[5:2] == reg_oen[5:2]);

  ////////////////////////////////////////
  // output registers
  ////////////////////////////////////////

  // full word writes, byte enables are not looked at
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      gpio_out <= '0;
      gpio_oe  <= '0;  // all pins start as inputs
    end else begin
      if (wr_out) gpio_out <= wdt[gpio_w-1:0];
      if (wr_oen) gpio_oe  <= wdt[gpio_w-1:0];
    end
  end

  ////////////////////////////////////////
  // input synchronizer
  ////////////////////////////////////////

  // pins are asynchronous to clk
  always_ff @(posedge clk) begin
    in_meta <= gpio_in;
    in_sync <= in_meta;
  end

  ////////////////////////////////////////
  // read back
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (vld && !wen) begin
      case (adr[5:2])
        reg_out[5:2]: rdt <= data_w'(gpio_out);
        reg_oen[5:2]: rdt <= data_w'(gpio_oe);
        reg_in[5:2]:  rdt <= data_w'(in_sync);
        default:      rdt <= '0;  // unmapped offsets read zero
      endcase
    end
  end

endmodule : soc_gpio

/* uart/soc_uart_tx.sv */
// uart transmitter
// register block with a transmit byte and a busy status,
// serializes 8N1 frames at a fixed divider

`timescale 1ns/1ns

module soc_uart_tx (
  input  logic                          clk,
  input  logic                          arst_n,
  // bus side
  input  logic                          vld,
  input  logic                          wen,
  input  logic [soc_bus_pkg::addr_w-1:0] adr,
  input  logic [soc_bus_pkg::data_w-1:0] wdt,
  output logic [soc_bus_pkg::data_w-1:0] rdt,
  // serial line
  output logic                          uart_txd
);

  import soc_bus_pkg::*;
  import soc_periph_pkg::*;

  uart_state_e          state;
  logic [baud_cw-1:0]   baud_cnt;  // clocks inside the current bit
  logic [bit_cw-1:0]    bit_cnt;   // data bit index
  logic [data_bits-1:0] shift;     // byte being sent, lsb goes out first
  logic                 baud_end;  // last clock of a bit
  logic                 txd_wr;    // accepted byte write
  logic                 busy;

  assign busy     = (state != st_idle);
  assign baud_end = (baud_cnt == baud_cw'(baud_div - 1));
  // writes while a frame is running are dropped here
  assign txd_wr   = vld & wen & (adr[5:2] == reg_txd[5:2]) & ~busy;

  ////////////////////////////////////////
  // baud counter
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      baud_cnt <= '0;
    end else if (!busy || baud_end) begin
      baud_cnt <= '0;               // idle holds zero, frame starts aligned
    end else begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////
  // frame FSM
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= st_idle;
      bit_cnt <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (txd_wr) state <= st_start;
        end
        st_start: begin
          if (baud_end) begin
            state   <= st_data;
            bit_cnt <= '0;
          end
        end
        st_data: begin
          if (baud_end) begin
            if (bit_cnt == bit_cw'(data_bits - 1)) begin
              state <= st_stop;      // last data bit done
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        st_stop: begin
          if (baud_end) state <= st_idle;  // busy drops here
        end
        default: state <= st_idle;
      endcase
    end
  end

  // shift register, loaded on the write and shifted after each data bit
  always_ff @(posedge clk) begin
    if (txd_wr) begin
      shift <= wdt[data_bits-1:0];
    end else if (state == st_data && baud_end) begin
      shift <= shift >> 1;
    end
  end

  // line level straight from state, start bit shows 1 cycle after the write
  always_comb begin
    case (state)
      st_start: uart_txd = 1'b0;
      st_data:  uart_txd = shift[0];
      default:  uart_txd = 1'b1;  // idle and stop
    endcase
  end

  ////////////////////////////////////////
  // read back
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (vld && !wen) begin
      if (adr[5:2] == reg_stat[5:2]) begin
        rdt <= data_w'(busy);
      end else begin
        rdt <= '0;  // reg_txd is write only
      end
    end
  end

  // line must rest high outside start and data bits
  a_txd_high : assert property (
    @(posedge clk) disable iff (!arst_n)
    (state inside {st_idle, st_stop}) |-> uart_txd
  );

  a_bit_cnt : assert property (
    @(posedge clk) disable iff (!arst_n)
    bit_cnt <= bit_cw'(data_bits - 1)
  );

endmodule : soc_uart_tx

/* verilog/soc_periph_top.sv */
// load/store subsystem top
// external request bus into the decoder, which feeds the data
// memory, the gpio controller and the uart transmitter

`timescale 1ns/1ns

module soc_periph_top (
  input  logic                             clk,
  input  logic                             arst_n,
  // load/store bus
  input  logic                             ls_vld,
  input  logic                             ls_wen,
  input  logic [soc_bus_pkg::addr_w-1:0]    ls_adr,
  input  logic [soc_bus_pkg::ben_w-1:0]     ls_ben,
  input  logic [soc_bus_pkg::data_w-1:0]    ls_wdt,
  output logic [soc_bus_pkg::data_w-1:0]    ls_rdt,
  // gpio pins
  output logic [soc_periph_pkg::gpio_w-1:0] gpio_out,
  output logic [soc_periph_pkg::gpio_w-1:0] gpio_oe,
  input  logic [soc_periph_pkg::gpio_w-1:0] gpio_in,
  // uart
  output logic                             uart_txd
);

  import soc_bus_pkg::*;

  logic              mem_vld, gpio_vld, uart_vld;  // decoded strobes
  logic [data_w-1:0] mem_rdt, gpio_rdt, uart_rdt;  // registered returns

  ////////////////////////////////////////
  // decoder
  ////////////////////////////////////////

  soc_bus_dec i_dec (
    .clk      (clk),
    .arst_n   (arst_n),
    .ls_vld   (ls_vld),
    .ls_wen   (ls_wen),
    .ls_adr   (ls_adr),
    .ls_rdt   (ls_rdt),
    .mem_vld  (mem_vld),
    .gpio_vld (gpio_vld),
    .uart_vld (uart_vld),
    .mem_rdt  (mem_rdt),
    .gpio_rdt (gpio_rdt),
    .uart_rdt (uart_rdt)
  );

  ////////////////////////////////////////
  // targets
  ////////////////////////////////////////

  // wen, adr, ben and wdt are shared, only the strobe differs
  soc_data_mem i_mem (
    .clk (clk),
    .vld (mem_vld),
    .wen (ls_wen),
    .adr (ls_adr),
    .ben (ls_ben),
    .wdt (ls_wdt),
    .rdt (mem_rdt)
  );

  soc_gpio i_gpio (
    .clk      (clk),
    .arst_n   (arst_n),
    .vld      (gpio_vld),
    .wen      (ls_wen),
    .adr      (ls_adr),
    .wdt      (ls_wdt),
    .rdt      (gpio_rdt),
    .gpio_out (gpio_out),
    .gpio_oe  (gpio_oe),
    .gpio_in  (gpio_in)
  );

  soc_uart_tx i_uart (
    .clk      (clk),
    .arst_n   (arst_n),
    .vld      (uart_vld),
    .wen      (ls_wen),
    .adr      (ls_adr),
    .wdt      (ls_wdt),
    .rdt      (uart_rdt),
    .uart_txd (uart_txd)
  );

endmodule : soc_periph_top

/* verification/tb_soc_tasks.svh */
// testbench helpers for the load/store subsystem
// lcg, bus tasks, reference models and a uart line decoder

`ifndef TB_SOC_TASKS_SVH
`define TB_SOC_TASKS_SVH

////////////////////////////////////////
// reference models
////////////////////////////////////////

logic [data_w-1:0] mem_model [2**mem_aw];  // byte merged image of the RAM
logic [gpio_w-1:0] gpio_out_m;
logic [gpio_w-1:0] gpio_oe_m;
int unsigned       tx_cyc;                 // strobe cycle of the accepted txd write

function automatic logic [31:0] next_rand();
  rng = rng * 32'd1664525 + 32'd1013904223;  // classic 32-bit lcg
  return rng;
endfunction

function automatic logic [addr_w-1:0] per_adr(logic [6:0] ofs);
  return (addr_w'(1) << sel_bit) | addr_w'(ofs);  // peripheral half
endfunction

function automatic void mem_merge(logic [mem_aw-1:0] idx, logic [ben_w-1:0] ben,
                                  logic [data_w-1:0] wdt);
  for (int b = 0; b < ben_w; b++) begin
    if (ben[b]) mem_model[idx][8*b +: 8] = wdt[8*b +: 8];
  end
endfunction

// busy from the cycle after the write until the stop bit ends
function automatic logic busy_exp(int unsigned rd_cyc);
  return (rd_cyc > tx_cyc) && (rd_cyc <= tx_cyc + frame_bits * baud_div);
endfunction

////////////////////////////////////////
// bus and checks
////////////////////////////////////////

task automatic bus_write(logic [addr_w-1:0] adr, logic [ben_w-1:0] ben,
                         logic [data_w-1:0] wdt);
  @(negedge clk);
  ls_vld   = 1'b1;
  ls_wen   = 1'b1;
  ls_adr   = adr;
  ls_ben   = ben;
  ls_wdt   = wdt;
  last_cyc = cyc + 1;  // edge that samples the strobe
  @(negedge clk);
  ls_vld = 1'b0;
endtask

task automatic bus_read(logic [addr_w-1:0] adr, output logic [data_w-1:0] rdt);
  @(negedge clk);
  ls_vld   = 1'b1;
  ls_wen   = 1'b0;
  ls_adr   = adr;
  last_cyc = cyc + 1;
  @(negedge clk);
  rdt    = ls_rdt;  // one cycle after the strobe
  ls_vld = 1'b0;
endtask

task automatic check_val(string what, logic [31:0] exp, logic [31:0] act);
  assert (act === exp) else begin
    $display("** Error %s %s: expected %h, actual %h", cur_test, what, exp, act);
    test_errs++;
  end
endtask

task automatic note_fail(string msg);
  $display("%s: %s", cur_test, msg);
  test_errs++;
endtask

// waits for the start bit, then samples every bit mid period
task automatic capture_uart(output logic [7:0] rx, output logic stop);
  int unsigned n;
  n    = 0;
  rx   = '0;
  stop = 1'b0;
  while (uart_txd !== 1'b0 && n < start_tmo) begin
    @(negedge clk);
    n++;
  end
  if (uart_txd !== 1'b0) begin
    note_fail("no start bit seen on uart_txd");
    return;
  end
  repeat (baud_div / 2) @(negedge clk);  // middle of the start bit
  check_val("start bit", 0, uart_txd);
  for (int i = 0; i < 8; i++) begin
    repeat (baud_div) @(negedge clk);
    rx[i] = uart_txd;  // lsb first
  end
  repeat (baud_div) @(negedge clk);
  stop = uart_txd;
endtask

`endif

/* verification/tb_soc_top.sv */
// testbench for the load/store subsystem
// random memory, gpio and uart traffic checked against models

`timescale 1ns/1ns

module tb_soc_top;

  import soc_bus_pkg::*;
  import soc_periph_pkg::*;

  localparam int unsigned mem_ops    = 200;
  localparam int unsigned frame_bits = 10;            // start, 8 data, stop
  localparam int unsigned start_tmo  = 4 * baud_div;  // cycles to see a start bit
  localparam int unsigned idle_tmo   = 100;           // status polls

  logic              clk;
  logic              arst_n;
  logic              ls_vld;
  logic              ls_wen;
  logic [addr_w-1:0] ls_adr;
  logic [ben_w-1:0]  ls_ben;
  logic [data_w-1:0] ls_wdt;
  logic [data_w-1:0] ls_rdt;
  logic [gpio_w-1:0] gpio_out;
  logic [gpio_w-1:0] gpio_oe;
  logic [gpio_w-1:0] gpio_in;
  logic              uart_txd;
  logic [31:0]       rng;
  int unsigned       cyc;       // rising edges so far
  int unsigned       last_cyc;  // edge of the last strobe
  int unsigned       test_errs;
  int unsigned       pass_cnt;
  int unsigned       fail_cnt;
  string             cur_test;

  `include "tb_soc_tasks.svh"

  soc_periph_top i_dut (
    .clk      (clk),
    .arst_n   (arst_n),
    .ls_vld   (ls_vld),
    .ls_wen   (ls_wen),
    .ls_adr   (ls_adr),
    .ls_ben   (ls_ben),
    .ls_wdt   (ls_wdt),
    .ls_rdt   (ls_rdt),
    .gpio_out (gpio_out),
    .gpio_oe  (gpio_oe),
    .gpio_in  (gpio_in),
    .uart_txd (uart_txd)
  );

  always #5 clk = ~clk;            // 10 ns
  always @(posedge clk) cyc <= cyc + 1;

  task automatic start_test(string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    if (test_errs == 0) begin
      pass_cnt++;
      $display("test %s passed", cur_test);
    end else begin
      fail_cnt++;
      $display("test %s failed with %0d errors", cur_test, test_errs);
    end
  endtask

  // polls reg_stat against the busy model until the frame is over
  task automatic wait_idle();
    logic [data_w-1:0] got;
    int unsigned       n;
    n   = 0;
    got = '1;
    while (got[0] && n < idle_tmo) begin
      bus_read(per_adr(reg_stat), got);
      check_val("busy", data_w'(busy_exp(last_cyc)), got);
      n++;
    end
    if (got[0]) note_fail("uart status stayed busy");
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic test_mem();
    logic [mem_aw-1:0] idx;
    logic [mem_aw-1:0] wq [$];  // words written so far
    logic [ben_w-1:0]  ben;
    logic [data_w-1:0] wdt;
    logic [data_w-1:0] got;
    logic [31:0]       r;
    start_test("mem");
    for (int n = 0; n < mem_ops; n++) begin
      idx = mem_aw'(next_rand() >> 8);
      ben = ben_w'(next_rand() >> 24);
      wdt = next_rand();
      bus_write(addr_w'(idx) << byte_ofs_w, ben, wdt);
      mem_merge(idx, ben, wdt);
      wq.push_back(idx);
      r = next_rand();
      if (r[20]) begin  // read back a word written earlier
        idx = wq[r[15:0] % wq.size()];
        bus_read(addr_w'(idx) << byte_ofs_w, got);
        check_val("read", mem_model[idx], got);
      end
    end
    end_test();
  endtask

  task automatic test_gpio_reg();
    logic [data_w-1:0] wdt;
    logic [data_w-1:0] got;
    start_test("gpio_reg");
    check_val("reset out", 0, gpio_out);
    check_val("reset oe", 0, gpio_oe);
    for (int n = 0; n < 20; n++) begin
      wdt = next_rand();
      if (n % 2 == 0) begin
        bus_write(per_adr(reg_out), '1, wdt);
        gpio_out_m = wdt;
      end else begin
        bus_write(per_adr(reg_oen), '1, wdt);
        gpio_oe_m = wdt;
      end
      check_val("gpio_out", gpio_out_m, gpio_out);  // one cycle after the strobe
      check_val("gpio_oe", gpio_oe_m, gpio_oe);
      bus_read(per_adr(n % 2 == 0 ? reg_out : reg_oen), got);
      check_val("readback", n % 2 == 0 ? gpio_out_m : gpio_oe_m, got);
    end
    end_test();
  endtask

  task automatic test_gpio_in();
    logic [gpio_w-1:0] pin;
    logic [data_w-1:0] got;
    start_test("gpio_in");
    for (int n = 0; n < 10; n++) begin
      @(negedge clk);
      pin     = next_rand();
      gpio_in = pin;
      repeat (2) @(negedge clk);  // read strobe goes out on the third negedge
      bus_read(per_adr(reg_in), got);
      check_val("gpio_in", pin, got);
    end
    end_test();
  endtask

  task automatic test_uart_frame();
    logic [7:0] tx;
    logic [7:0] rx;
    logic       stop;
    start_test("uart_frame");
    check_val("reset txd", 1, uart_txd);
    for (int n = 0; n < 3; n++) begin
      tx = 8'(next_rand() >> 16);
      bus_write(per_adr(reg_txd), '1, data_w'(tx));
      tx_cyc = last_cyc;
      fork
        capture_uart(rx, stop);
        begin
          repeat (3 * baud_div) @(negedge clk);  // well inside the frame
          wait_idle();
        end
      join
      check_val("rx byte", tx, rx);
      check_val("stop bit", 1, stop);
    end
    end_test();
  endtask

  task automatic test_uart_busy();
    logic [7:0]        tx;
    logic [7:0]        rx;
    logic              stop;
    logic [addr_w-1:0] adr;
    logic [data_w-1:0] wdt;
    logic [data_w-1:0] got;
    start_test("uart_busy");
    tx = 8'(next_rand() >> 16);
    bus_write(per_adr(reg_txd), '1, data_w'(tx));
    tx_cyc = last_cyc;
    fork
      capture_uart(rx, stop);
      begin
        repeat (12) @(negedge clk);
        bus_write(per_adr(reg_txd), '1, data_w'(~tx));  // dropped, frame running
        wait_idle();
      end
    join
    check_val("rx byte", tx, rx);
    check_val("stop bit", 1, stop);
    // second byte never goes out
    repeat (frame_bits * baud_div) begin
      @(negedge clk);
      check_val("line idle", 1, uart_txd);
    end
    // memory writes whose low bits alias gpio and uart offsets
    for (int n = 0; n < 20; n++) begin
      adr          = addr_w'(next_rand() >> 4);
      adr[sel_bit] = 1'b0;
      adr[6:0]     = (n % 2) ? reg_txd : reg_out;
      wdt          = next_rand();
      bus_write(adr, '1, wdt);
      mem_merge(mem_aw'(adr >> byte_ofs_w), '1, wdt);
      check_val("gpio_out", gpio_out_m, gpio_out);
      check_val("uart_txd", 1, uart_txd);
    end
    bus_read(adr, got);
    check_val("mem word", mem_model[mem_aw'(adr >> byte_ofs_w)], got);
    bus_read(per_adr(reg_stat), got);
    check_val("status", 0, got);
    end_test();
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    clk        = 1'b0;
    arst_n     = 1'b0;
    ls_vld     = 1'b0;
    ls_wen     = 1'b0;
    ls_adr     = '0;
    ls_ben     = '0;
    ls_wdt     = '0;
    gpio_in    = '0;
    rng        = 32'ha51dc8d9;
    cyc        = 0;
    last_cyc   = 0;
    pass_cnt   = 0;
    fail_cnt   = 0;
    gpio_out_m = '0;  // reset values
    gpio_oe_m  = '0;
    tx_cyc     = 0;
    repeat (2) @(negedge clk);
    arst_n = 1'b1;
    test_mem();
    test_gpio_reg();
    test_gpio_in();
    test_uart_frame();
    test_uart_busy();
    $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule : tb_soc_top

/* tb.f */
+incdir+verification
common/soc_bus_pkg.sv
common/soc_periph_pkg.sv
verilog/soc_bus_dec.sv
verilog/soc_data_mem.sv
verilog/soc_gpio.sv
uart/soc_uart_tx.sv
verilog/soc_periph_top.sv
verification/tb_soc_top.sv
